// ==== eth_mac_cfg.svh ====
`ifndef ETH_MAC_CFG_SVH
`define ETH_MAC_CFG_SVH

// transmit payload buffer, in bytes
`define ETH_TX_BUF_DEPTH   64
`define ETH_MIN_PAYLOAD    46
`define ETH_PREAMBLE_LEN   7
`define ETH_IFG_LEN        12
`define ETH_HDR_LEN        14
`define ETH_FCS_LEN        4
`define ETH_PREAMBLE_BYTE  8'h55
`define ETH_SFD_BYTE       8'hd5

// reflected crc-32, register value left after data plus fcs
`define ETH_CRC_POLY       32'hedb88320
`define ETH_CRC_INIT       32'hffffffff
`define ETH_CRC_RESIDUE    32'hdebb20e3

`endif

// ==== eth_mac_pkg.sv ====
package eth_mac_pkg;

  typedef logic [7:0]  byte_t;
  // most significant byte goes on the wire first
  typedef logic [47:0] mac_addr_t;
  typedef logic [15:0] ethertype_t;
  typedef logic [15:0] frame_len_t;

  // rx header out, tx request in
  // tx ignores src and length
  typedef struct packed {
    mac_addr_t  dst;
    mac_addr_t  src;
    ethertype_t ethertype;
    frame_len_t length;
  } mac_hdr_t;

  // byte-wide phy, same shape both directions
  typedef struct packed {
    byte_t d;
    logic  v;
    logic  e;
  } phy_bus_t;

  typedef enum logic [3:0] {
    tx_idle,
    tx_preamble,
    tx_dst,
    tx_src,
    tx_type,
    tx_payload,
    tx_pad,
    tx_fcs,
    tx_gap
  } tx_state_t;

endpackage

// ==== crc32.sv ====
`timescale 1ns/100ps

`include "eth_mac_cfg.svh"

module crc32 (
  input  logic               clk,
  input  logic               fsm_rst,
  input  logic               init,
  input  eth_mac_pkg::byte_t d,
  input  logic               en,
  output logic [31:0]        crc,
  output logic               ok
);

  import eth_mac_pkg::*;

  logic [31:0] crc_q;
  logic [31:0] seed;

  // one byte, lsb first
  function automatic logic [31:0] fold_byte(input logic [31:0] c, input byte_t b);
    logic [31:0] r;
    r = c ^ {24'h000000, b};
    for (int i = 0; i < 8; i++) begin
      r = r[0] ? ((r >> 1) ^ `ETH_CRC_POLY) : (r >> 1);
    end
    return r;
  endfunction

  // init together with en starts a fresh sum with this byte
  assign seed = init ? `ETH_CRC_INIT : crc_q;

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      crc_q <= `ETH_CRC_INIT;
    end else if (en) begin
      crc_q <= fold_byte(seed, d);
    end else if (init) begin
      crc_q <= `ETH_CRC_INIT;
    end
  end

  // fcs to send, byte 0 goes out first
  assign crc = ~crc_q;
  assign ok  = (crc_q == `ETH_CRC_RESIDUE);

endmodule

// ==== eth_mac_rx.sv ====
`timescale 1ns/100ps

`include "eth_mac_cfg.svh"

module eth_mac_rx (
  input  logic                  clk,
  input  logic                  fsm_rst,
  input  eth_mac_pkg::phy_bus_t phy_rx,
  output eth_mac_pkg::byte_t    rx_d,
  output logic                  rx_v,
  output logic                  rx_sof,
  output logic                  rx_done,
  output logic                  rx_err,
  output eth_mac_pkg::mac_hdr_t rx_hdr
);

  import eth_mac_pkg::*;

  typedef enum logic [1:0] {
    rx_hunt,
    rx_header,
    rx_payload
  } rx_state_t;

  localparam int         hdr_bits = 8 * `ETH_HDR_LEN;
  localparam logic [3:0] hdr_last = 4'(`ETH_HDR_LEN - 1);
  localparam logic [2:0] fcs_len  = 3'(`ETH_FCS_LEN);

  rx_state_t                    state;
  logic [3:0]                   hdr_cnt;
  logic [hdr_bits-1:0]          hdr_sr;
  byte_t [`ETH_FCS_LEN-1:0]     dl;
  logic [2:0]                   fill;
  frame_len_t                   out_cnt;
  frame_len_t                   len_q;
  logic                         v_q;
  logic                         phy_err;
  logic                         err_q;
  logic                         eof_q;
  logic                         fall;
  logic                         emit;
  logic                         crc_init;
  logic                         crc_en;
  logic                         crc_ok;

  assign fall = v_q && !phy_rx.v;

  // a byte leaves only once four newer bytes sit behind it
  assign emit = (state == rx_payload) && phy_rx.v && (fill == fcs_len);

  // sum restarts while hunting, covers header, payload and fcs
  assign crc_init = (state == rx_hunt);
  assign crc_en   = phy_rx.v && (state != rx_hunt);

  crc32 crc32_inst (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .init    (crc_init),
    .d       (phy_rx.d),
    .en      (crc_en),
    .crc     (),
    .ok      (crc_ok)
  );

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state   <= rx_hunt;
      hdr_cnt <= '0;
      fill    <= '0;
      out_cnt <= '0;
      v_q     <= 1'b0;
      phy_err <= 1'b0;
      err_q   <= 1'b0;
      eof_q   <= 1'b0;
      rx_v    <= 1'b0;
      rx_sof  <= 1'b0;
      rx_done <= 1'b0;
      rx_err  <= 1'b0;
    end else begin
      v_q     <= phy_rx.v;
      rx_v    <= emit;
      rx_sof  <= emit && (out_cnt == '0);
      eof_q   <= fall;
      rx_done <= eof_q;
      rx_err  <= eof_q && err_q;
      if (emit) begin
        out_cnt <= out_cnt + 16'd1;
      end
      if (fall) begin
        // end of frame status, then back to hunting
        err_q   <= !crc_ok || phy_err || (fill != fcs_len);
        state   <= rx_hunt;
        hdr_cnt <= '0;
        fill    <= '0;
        out_cnt <= '0;
        phy_err <= 1'b0;
      end else begin
        if (phy_rx.v && phy_rx.e) begin
          phy_err <= 1'b1;
        end
        case (state)
          rx_hunt: begin
            hdr_cnt <= '0;
            if (phy_rx.v && phy_rx.d == `ETH_SFD_BYTE) begin
              state <= rx_header;
            end
          end
          rx_header: begin
            if (phy_rx.v) begin
              hdr_cnt <= hdr_cnt + 4'd1;
              if (hdr_cnt == hdr_last) begin
                state <= rx_payload;
              end
            end
          end
          rx_payload: begin
            if (phy_rx.v && fill != fcs_len) begin
              fill <= fill + 3'd1;
            end
          end
          default: state <= rx_hunt;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state == rx_header && phy_rx.v) begin
      hdr_sr <= {hdr_sr[hdr_bits-9:0], phy_rx.d};
    end
    // fcs delay line
    if (state == rx_payload && phy_rx.v) begin
      dl <= {dl[`ETH_FCS_LEN-2:0], phy_rx.d};
    end
    if (emit) begin
      rx_d <= dl[`ETH_FCS_LEN-1];
    end
    if (fall) begin
      len_q <= out_cnt;
    end
    // header held until the next frame ends
    if (eof_q) begin
      rx_hdr <= '{dst:       hdr_sr[hdr_bits-1 -: 48],
                  src:       hdr_sr[hdr_bits-49 -: 48],
                  ethertype: hdr_sr[15:0],
                  length:    len_q};
    end
  end

endmodule

// ==== eth_mac_tx.sv ====
`timescale 1ns/100ps

`include "eth_mac_cfg.svh"

module eth_mac_tx (
  input  logic                  clk,
  input  logic                  fsm_rst,
  input  eth_mac_pkg::mac_addr_t local_mac,
  input  eth_mac_pkg::byte_t    tx_d,
  input  logic                  tx_v,
  input  logic                  tx_avl,
  input  eth_mac_pkg::mac_hdr_t tx_hdr,
  output logic                  tx_rdy,
  output eth_mac_pkg::phy_bus_t phy_tx
);

  import eth_mac_pkg::*;

  localparam int         aw        = $clog2(`ETH_TX_BUF_DEPTH);
  localparam logic [3:0] pre_last  = 4'(`ETH_PREAMBLE_LEN);
  localparam logic [3:0] addr_last = 4'd5;
  localparam logic [3:0] type_last = 4'd1;
  localparam logic [3:0] fcs_last  = 4'(`ETH_FCS_LEN - 1);
  localparam logic [3:0] gap_last  = 4'(`ETH_IFG_LEN - 1);
  localparam frame_len_t min_pay   = frame_len_t'(`ETH_MIN_PAYLOAD);

  tx_state_t   state;
  logic [3:0]  seg_cnt;
  frame_len_t  pay_cnt;
  frame_len_t  len;
  logic [aw:0] wr_ptr;
  logic [aw-1:0] rd_ptr;
  byte_t       buf_mem [`ETH_TX_BUF_DEPTH];
  mac_addr_t   dst_sr;
  mac_addr_t   src_sr;
  ethertype_t  type_sr;
  byte_t       tx_byte;
  logic        frame_on;
  logic [31:0] crc;
  logic        crc_init;
  logic        crc_en;

  // byte for the current state, registered onto the phy next edge
  always_comb begin
    tx_byte = 8'h00;
    case (state)
      tx_preamble: begin
        tx_byte = (seg_cnt == pre_last) ? `ETH_SFD_BYTE : `ETH_PREAMBLE_BYTE;
      end
      tx_dst:     tx_byte = dst_sr[47 -: 8];
      tx_src:     tx_byte = src_sr[47 -: 8];
      tx_type:    tx_byte = type_sr[15 -: 8];
      tx_payload: tx_byte = buf_mem[rd_ptr];
      tx_fcs:     tx_byte = crc[8*seg_cnt[1:0] +: 8];
      default:    tx_byte = 8'h00;
    endcase
  end

  assign frame_on = state inside {tx_preamble, tx_dst, tx_src, tx_type,
                                  tx_payload, tx_pad, tx_fcs};

  // register is loaded during preamble and frozen while fcs goes out
  assign crc_init = (state == tx_preamble);
  assign crc_en   = state inside {tx_dst, tx_src, tx_type, tx_payload, tx_pad};

  crc32 crc32_inst (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .init    (crc_init),
    .d       (tx_byte),
    .en      (crc_en),
    .crc     (crc),
    .ok      ()
  );

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state   <= tx_idle;
      seg_cnt <= '0;
      pay_cnt <= '0;
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      tx_rdy  <= 1'b0;
      phy_tx  <= '0;
    end else begin
      tx_rdy   <= 1'b0;
      phy_tx.d <= tx_byte;
      phy_tx.v <= frame_on;
      phy_tx.e <= 1'b0;
      seg_cnt  <= seg_cnt + 4'd1;
      if (tx_v) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      case (state)
        tx_idle: begin
          seg_cnt <= '0;
          // header and buffer taken as one frame here
          if (tx_avl) begin
            tx_rdy <= 1'b1;
            state  <= tx_preamble;
          end
        end
        tx_preamble: begin
          if (seg_cnt == pre_last) begin
            seg_cnt <= '0;
            state   <= tx_dst;
          end
        end
        tx_dst: begin
          if (seg_cnt == addr_last) begin
            seg_cnt <= '0;
            state   <= tx_src;
          end
        end
        tx_src: begin
          if (seg_cnt == addr_last) begin
            seg_cnt <= '0;
            state   <= tx_type;
          end
        end
        tx_type: begin
          if (seg_cnt == type_last) begin
            seg_cnt <= '0;
            pay_cnt <= '0;
            state   <= (len == '0) ? tx_pad : tx_payload;
          end
        end
        tx_payload: begin
          pay_cnt <= pay_cnt + 16'd1;
          rd_ptr  <= rd_ptr + 1'b1;
          if (pay_cnt + 16'd1 == len) begin
            seg_cnt <= '0;
            state   <= (len >= min_pay) ? tx_fcs : tx_pad;
          end
        end
        tx_pad: begin
          pay_cnt <= pay_cnt + 16'd1;
          if (pay_cnt + 16'd1 == min_pay) begin
            seg_cnt <= '0;
            state   <= tx_fcs;
          end
        end
        tx_fcs: begin
          if (seg_cnt == fcs_last) begin
            // buffer is free for the next payload
            seg_cnt <= '0;
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            state   <= tx_gap;
          end
        end
        tx_gap: begin
          if (seg_cnt == gap_last) begin
            state <= tx_idle;
          end
        end
        default: state <= tx_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (tx_v) begin
      buf_mem[wr_ptr[aw-1:0]] <= tx_d;
    end
  end

  // header fields shift out msb first
  always_ff @(posedge clk) begin
    case (state)
      tx_idle: begin
        if (tx_avl) begin
          dst_sr  <= tx_hdr.dst;
          src_sr  <= local_mac;
          type_sr <= tx_hdr.ethertype;
          len     <= frame_len_t'(wr_ptr);
        end
      end
      tx_dst:  dst_sr  <= {dst_sr[39:0], 8'h00};
      tx_src:  src_sr  <= {src_sr[39:0], 8'h00};
      tx_type: type_sr <= {type_sr[7:0], 8'h00};
      default: ;
    endcase
  end

endmodule

// ==== eth_mac.sv ====
`timescale 1ns/100ps

module eth_mac (
  input  logic                   clk,
  input  logic                   fsm_rst,
  input  eth_mac_pkg::mac_addr_t local_mac,

  // phy side
  input  eth_mac_pkg::phy_bus_t  phy_rx,
  output eth_mac_pkg::phy_bus_t  phy_tx,

  // transmit client
  input  eth_mac_pkg::byte_t     tx_d,
  input  logic                   tx_v,
  input  logic                   tx_avl,
  input  eth_mac_pkg::mac_hdr_t  tx_hdr,
  output logic                   tx_rdy,

  // receive client
  output eth_mac_pkg::byte_t     rx_d,
  output logic                   rx_v,
  output logic                   rx_sof,
  output logic                   rx_done,
  output logic                   rx_err,
  output eth_mac_pkg::mac_hdr_t  rx_hdr
);

  eth_mac_rx eth_mac_rx_inst (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .phy_rx  (phy_rx),
    .rx_d    (rx_d),
    .rx_v    (rx_v),
    .rx_sof  (rx_sof),
    .rx_done (rx_done),
    .rx_err  (rx_err),
    .rx_hdr  (rx_hdr)
  );

  // source address comes from local_mac, not from tx_hdr
  eth_mac_tx eth_mac_tx_inst (
    .clk       (clk),
    .fsm_rst   (fsm_rst),
    .local_mac (local_mac),
    .tx_d      (tx_d),
    .tx_v      (tx_v),
    .tx_avl    (tx_avl),
    .tx_hdr    (tx_hdr),
    .tx_rdy    (tx_rdy),
    .phy_tx    (phy_tx)
  );

endmodule

// ==== tb_eth_mac.sv ====
`timescale 1ns/100ps

`include "eth_mac_cfg.svh"

module tb_eth_mac;

  import eth_mac_pkg::*;

  localparam int timeout_cycles = 1000;

  logic      clk;
  logic      fsm_rst;
  mac_addr_t local_mac;
  phy_bus_t  phy_rx;
  phy_bus_t  phy_tx;
  phy_bus_t  inj;
  logic      loop_en;
  byte_t     tx_d;
  logic      tx_v;
  logic      tx_avl;
  mac_hdr_t  tx_hdr;
  logic      tx_rdy;
  byte_t     rx_d;
  logic      rx_v;
  logic      rx_sof;
  logic      rx_done;
  logic      rx_err;
  mac_hdr_t  rx_hdr;

  logic [31:0] rand_state;
  string       test_name;
  int          errors;
  int          checks;
  int          tests;
  int          test_start_errs;
  byte_t       pay_q[$];
  byte_t       frame_q[$];
  byte_t       rx_q[$];
  byte_t       tx_q[$];
  int          tx_lens[$];
  int          gaps[$];
  int          cyc;
  int          rdy_cyc;
  int          rise_cyc;
  int          rdy_count;
  int          run_len;
  int          low_len;
  int          sof_idx;
  logic        prev_v;
  logic        seen_frame;
  logic        tx_e_seen;
  mac_hdr_t    got_hdr;
  logic        got_err;

  // phy loopback or injected frames
  assign phy_rx = loop_en ? phy_tx : inj;

  eth_mac DUT (
    .clk       (clk),
    .fsm_rst   (fsm_rst),
    .local_mac (local_mac),
    .phy_rx    (phy_rx),
    .phy_tx    (phy_tx),
    .tx_d      (tx_d),
    .tx_v      (tx_v),
    .tx_avl    (tx_avl),
    .tx_hdr    (tx_hdr),
    .tx_rdy    (tx_rdy),
    .rx_d      (rx_d),
    .rx_v      (rx_v),
    .rx_sof    (rx_sof),
    .rx_done   (rx_done),
    .rx_err    (rx_err),
    .rx_hdr    (rx_hdr)
  );

  always #5 clk = ~clk;

  // sample outputs on the falling edge where they are stable
  always @(negedge clk) begin
    cyc = cyc + 1;
    if (rx_v) begin
      if (rx_sof) sof_idx = rx_q.size();
      rx_q.push_back(rx_d);
    end
    if (tx_rdy) begin
      rdy_cyc   = cyc;
      rdy_count = rdy_count + 1;
    end
    if (phy_tx.e) tx_e_seen = 1'b1;
    if (phy_tx.v) begin
      tx_q.push_back(phy_tx.d);
      if (!prev_v) begin
        rise_cyc = cyc;
        if (seen_frame) gaps.push_back(low_len);
        run_len = 0;
      end
      run_len = run_len + 1;
    end else begin
      if (prev_v) begin
        tx_lens.push_back(run_len);
        seen_frame = 1'b1;
        low_len    = 0;
      end
      low_len = low_len + 1;
    end
    prev_v = phy_tx.v;
  end

  function automatic logic [31:0] next_rand();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
  endfunction

  function automatic int rand_range(input int lo, input int hi);
    return lo + int'((next_rand() >> 8) % (hi - lo + 1));
  endfunction

  // bit serial reflected crc taking data lsb first
  function automatic logic [31:0] crc_step(input logic [31:0] c, input byte_t b);
    logic fb;
    for (int i = 0; i < 8; i++) begin
      fb = c[0] ^ b[i];
      c  = {1'b0, c[31:1]};
      if (fb) c = c ^ `ETH_CRC_POLY;
    end
    return c;
  endfunction

  task automatic check_byte(input string what, input byte_t exp, input byte_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("Fail %s: %s expected %h actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic check_hdr(input string what, input mac_hdr_t exp, input mac_hdr_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("Fail %s: %s expected %h actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic check_len(input string what, input frame_len_t exp, input frame_len_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("Fail %s: %s expected %0d actual %0d", test_name, what, exp, act);
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("Fail %s: %s expected %b actual %b", test_name, what, exp, act);
    end
  endtask

  task automatic report_timeout(input string what);
    errors++;
    $display("%s: timed out waiting for %s", test_name, what);
  endtask

  task automatic clear_mon();
    rx_q.delete();
    tx_q.delete();
    tx_lens.delete();
    gaps.delete();
    rdy_count  = 0;
    sof_idx    = -1;
    seen_frame = 1'b0;
    tx_e_seen  = 1'b0;
    low_len    = 0;
  endtask

  task automatic start_test(input string name);
    test_name       = name;
    test_start_errs = errors;
    clear_mon();
  endtask

  task automatic end_test();
    tests++;
    if (errors == test_start_errs) begin
      $display("%s: pass", test_name);
    end else begin
      $display("%s: fail, %0d errors", test_name, errors - test_start_errs);
    end
  endtask

  task automatic make_payload(input int n);
    logic [31:0] r;
    pay_q.delete();
    for (int i = 0; i < n; i++) begin
      r = next_rand();
      pay_q.push_back(r[23:16]);
    end
  endtask

  // preamble, sfd, header, padded payload, fcs lsb first
  task automatic build_frame(input mac_addr_t dst, input mac_addr_t src, input ethertype_t et);
    logic [31:0] c;
    byte_t       b;
    int          m;
    m = (pay_q.size() > `ETH_MIN_PAYLOAD) ? pay_q.size() : `ETH_MIN_PAYLOAD;
    c = `ETH_CRC_INIT;
    frame_q.delete();
    for (int i = 0; i < `ETH_PREAMBLE_LEN; i++) begin
      frame_q.push_back(`ETH_PREAMBLE_BYTE);
    end
    frame_q.push_back(`ETH_SFD_BYTE);
    for (int i = 0; i < `ETH_HDR_LEN + m; i++) begin
      if (i < 6) b = dst[47 - 8 * i -: 8];
      else if (i < 12) b = src[47 - 8 * (i - 6) -: 8];
      else if (i < 14) b = et[15 - 8 * (i - 12) -: 8];
      else if (i - 14 < pay_q.size()) b = pay_q[i - 14];
      else b = 8'h00;
      frame_q.push_back(b);
      c = crc_step(c, b);
    end
    for (int i = 0; i < 4; i++) begin
      frame_q.push_back(~c[8 * i +: 8]);
    end
  endtask

  task automatic load_payload();
    foreach (pay_q[i]) begin
      tx_d = pay_q[i];
      tx_v = 1'b1;
      @(negedge clk);
    end
    tx_v = 1'b0;
  endtask

  task automatic load_and_offer(input mac_hdr_t h);
    int n;
    load_payload();
    tx_hdr = h;
    tx_avl = 1'b1;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!tx_rdy && n < timeout_cycles);
    if (!tx_rdy) report_timeout("tx_rdy");
    tx_avl = 1'b0;
  endtask

  task automatic wait_done();
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!rx_done && n < timeout_cycles);
    if (!rx_done) begin
      report_timeout("rx_done");
    end else begin
      got_hdr = rx_hdr;
      got_err = rx_err;
    end
  endtask

  task automatic wait_rx_v();
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!rx_v && n < timeout_cycles);
    if (!rx_v) report_timeout("rx_v");
  endtask

  // both phy directions idle for longer than the gap
  task automatic wait_quiet();
    int n;
    int q;
    n = 0;
    q = 0;
    while (q < `ETH_IFG_LEN + 2 && n < timeout_cycles) begin
      @(negedge clk);
      n++;
      q = (phy_tx.v || phy_rx.v) ? 0 : q + 1;
    end
    if (q < `ETH_IFG_LEN + 2) report_timeout("idle phy");
  endtask

  // hold reset for 8 cycles, then the control outputs must read low
  task automatic reset_and_check();
    fsm_rst = 1'b1;
    repeat (8) @(negedge clk);
    fsm_rst = 1'b0;
    check_bit("tx_rdy after reset", 1'b0, tx_rdy);
    check_bit("phy_tx valid after reset", 1'b0, phy_tx.v);
    check_bit("rx_v after reset", 1'b0, rx_v);
    check_bit("rx_done after reset", 1'b0, rx_done);
  endtask

  task automatic loop_frame(input int n);
    mac_hdr_t    h;
    mac_hdr_t    exp_hdr;
    logic [31:0] r1;
    logic [31:0] r2;
    int          m;
    make_payload(n);
    r1          = next_rand();
    r2          = next_rand();
    h           = '0;
    h.dst       = {r1[15:0], r2};
    h.ethertype = r1[31:16];
    m = (n > `ETH_MIN_PAYLOAD) ? n : `ETH_MIN_PAYLOAD;
    clear_mon();
    load_and_offer(h);
    wait_done();
    exp_hdr = '{dst: h.dst, src: local_mac, ethertype: h.ethertype, length: frame_len_t'(m)};
    check_hdr("rx header", exp_hdr, got_hdr);
    check_bit("rx_err", 1'b0, got_err);
    check_bit("rx_sof on first byte", 1'b1, sof_idx == 0);
    check_len("rx byte count", frame_len_t'(m), frame_len_t'(rx_q.size()));
    for (int i = 0; i < rx_q.size() && i < m; i++) begin
      check_byte($sformatf("rx byte %0d", i), (i < n) ? pay_q[i] : 8'h00, rx_q[i]);
    end
    // wire image against the model frame
    build_frame(h.dst, local_mac, h.ethertype);
    check_len("tx byte count", frame_len_t'(frame_q.size()), frame_len_t'(tx_q.size()));
    for (int i = 0; i < tx_q.size() && i < frame_q.size(); i++) begin
      check_byte($sformatf("tx byte %0d", i), frame_q[i], tx_q[i]);
    end
    check_len("tx valid cycles", frame_len_t'(8 + 14 + m + 4),
              frame_len_t'((tx_lens.size() > 0) ? tx_lens[0] : 0));
    check_len("tx_rdy to valid", 16'd1, frame_len_t'(rise_cyc - rdy_cyc));
    check_bit("phy_tx error", 1'b0, tx_e_seen);
    wait_quiet();
  endtask

  task automatic hold_two_frames();
    int pulses;
    int n;
    int m;
    m = rand_range(1, `ETH_TX_BUF_DEPTH);
    make_payload(m);
    load_payload();
    tx_hdr = '0;
    tx_hdr.dst = {16'h0a0b, next_rand()};
    tx_avl = 1'b1;
    pulses = 0;
    n = 0;
    while (pulses < 2 && n < 4 * timeout_cycles) begin
      @(negedge clk);
      n++;
      if (tx_rdy) pulses++;
    end
    tx_avl = 1'b0;
    if (pulses < 2) report_timeout("second tx_rdy");
    wait_done();
    wait_quiet();
    check_len("tx_rdy pulses", 16'd2, frame_len_t'(rdy_count));
    check_len("frames sent", 16'd2, frame_len_t'(tx_lens.size()));
    if (gaps.size() > 0) begin
      check_bit("valid low for the gap", 1'b1, gaps[0] >= `ETH_IFG_LEN);
    end else begin
      errors++;
      $display("%s: no gap between frames was seen", test_name);
    end
    // second frame finds the buffer empty, so it is all padding
    if (tx_lens.size() == 2) begin
      check_len("second frame cycles", frame_len_t'(26 + `ETH_MIN_PAYLOAD),
                frame_len_t'(tx_lens[1]));
    end
  endtask

  task automatic inject_frame(input logic do_flip, input logic do_bad, input logic exp_err);
    mac_hdr_t    exp_hdr;
    logic [31:0] r1;
    logic [31:0] r2;
    int          idx;
    make_payload(rand_range(`ETH_MIN_PAYLOAD, `ETH_TX_BUF_DEPTH));
    r1 = next_rand();
    r2 = next_rand();
    exp_hdr = '{dst: {r1[15:0], r2}, src: {r2[15:0], next_rand()},
                ethertype: r1[31:16], length: frame_len_t'(pay_q.size())};
    build_frame(exp_hdr.dst, exp_hdr.src, exp_hdr.ethertype);
    idx = rand_range(8, frame_q.size() - 1);
    loop_en = 1'b0;
    foreach (frame_q[i]) begin
      inj.d = frame_q[i] ^ ((do_flip && i == idx) ? 8'h04 : 8'h00);
      inj.v = 1'b1;
      inj.e = do_bad && (i == idx);
      @(negedge clk);
    end
    inj = '0;
    wait_done();
    check_bit("rx_err", exp_err, got_err);
    if (!exp_err) check_hdr("rx header", exp_hdr, got_hdr);
    wait_quiet();
    loop_en = 1'b1;
  endtask

  initial begin
    clk        = 1'b0;
    fsm_rst    = 1'b1;
    inj        = '0;
    loop_en    = 1'b1;
    tx_d       = '0;
    tx_v       = 1'b0;
    tx_avl     = 1'b0;
    tx_hdr     = '0;
    rand_state = 32'h7405;
    local_mac  = {16'h0200, next_rand()};
    errors     = 0;
    checks     = 0;
    tests      = 0;
    cyc        = 0;
    prev_v     = 1'b0;
    got_hdr    = '0;
    got_err    = 1'b0;
    test_name  = "reset";
    clear_mon();
    repeat (8) @(negedge clk);
    fsm_rst = 1'b0;

    start_test("loopback full size");
    for (int k = 0; k < 6; k++) begin
      loop_frame(rand_range(`ETH_MIN_PAYLOAD, `ETH_TX_BUF_DEPTH));
    end
    end_test();

    start_test("padding");
    for (int k = 0; k < 6; k++) begin
      loop_frame(rand_range(1, `ETH_MIN_PAYLOAD - 1));
    end
    end_test();

    start_test("tx byte stream");
    loop_frame(rand_range(1, `ETH_TX_BUF_DEPTH));
    end_test();

    start_test("gap and back-pressure");
    hold_two_frames();
    end_test();

    start_test("crc error");
    inject_frame(1'b0, 1'b0, 1'b0);
    inject_frame(1'b1, 1'b0, 1'b1);
    end_test();

    start_test("phy error and reset");
    inject_frame(1'b0, 1'b1, 1'b1);
    // reset while tx_rdy is high
    make_payload(30);
    load_and_offer('0);
    reset_and_check();
    wait_quiet();
    // reset while payload streams out on rx
    make_payload(30);
    load_and_offer('0);
    wait_rx_v();
    reset_and_check();
    wait_quiet();
    // reset while rx_done is high
    make_payload(30);
    load_and_offer('0);
    wait_done();
    reset_and_check();
    wait_quiet();
    loop_frame(rand_range(1, `ETH_TX_BUF_DEPTH));
    end_test();

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+.
eth_mac_pkg.sv
crc32.sv
eth_mac_rx.sv
eth_mac_tx.sv
eth_mac.sv
tb_eth_mac.sv

// ==== Makefile ====
VERILATOR  := verilator
FLAGS      := --binary --timing -Wno-fatal
LINT_FLAGS := --lint-only --timing -Wall
TOP        := tb_eth_mac
FILELIST   := files.f
OBJ_DIR    := obj_dir
PASS_MSG   := Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# fails unless the pass line shows up in the output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
